//--- rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] wordT;
    typedef logic [3:0]      maskT;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } aluOpT;

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } sizeT;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10,
        WB_IMM = 2'b11
    } wbSelT;

endpackage

`default_nettype wire

//--- controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  rvPkg::wordT  instruction,
    input  logic [1:0]   addrLow,
    input  logic         aluZero,
    input  logic         aluLess,
    output rvPkg::aluOpT aluOp,
    output logic         aluSrcImm,
    output logic         jump,
    output logic         jumpReg,
    output logic         branchTaken,
    output rvPkg::sizeT  memSize,
    output logic         loadUnsigned,
    output logic         memWr,
    output logic         regWr,
    output rvPkg::wbSelT wbSel,
    output logic         except
);
    import rvPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;
    logic       misaligned;
    logic       isAccess;
    logic       memWrDec;
    logic       regWrDec;
    logic       jumpDec;
    logic       jumpRegDec;
    logic       branchDec;
    logic       condMet;

    // alt selects SUB / SRA
    function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arithOp = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arithOp = ALU_SLL;
            3'b010:  arithOp = ALU_SLT;
            3'b011:  arithOp = ALU_SLTU;
            3'b100:  arithOp = ALU_XOR;
            3'b101:  arithOp = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    endfunction

    assign opcode = opcodeT'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        aluOp        = ALU_ADD;
        aluSrcImm    = 1'b0;
        jumpDec      = 1'b0;
        jumpRegDec   = 1'b0;
        branchDec    = 1'b0;
        memSize      = sizeT'(funct3[1:0]);
        loadUnsigned = funct3[2];
        isAccess     = 1'b0;
        memWrDec     = 1'b0;
        regWrDec     = 1'b0;
        wbSel        = WB_ALU;
        illegal      = 1'b0;
        case (opcode)
            OPC_OP: begin
                regWrDec = 1'b1;
                aluOp    = arithOp(funct3, funct7[5]);
                illegal  = !(funct7 == 7'h00 ||
                             (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                regWrDec  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = arithOp(funct3, funct7[5] && funct3 == 3'b101);
                // shift-immediates carry funct7 in the immediate field
                if (funct3 == 3'b001) begin
                    illegal = funct7 != 7'h00;
                end else if (funct3 == 3'b101) begin
                    illegal = funct7 != 7'h00 && funct7 != 7'h20;
                end
            end
            OPC_LOAD: begin
                regWrDec  = 1'b1;
                aluSrcImm = 1'b1;
                isAccess  = 1'b1;
                wbSel     = WB_MEM;
                illegal   = funct3[1:0] == 2'b11 || (funct3[2] && funct3[1]);
            end
            OPC_STORE: begin
                memWrDec  = 1'b1;
                aluSrcImm = 1'b1;
                isAccess  = 1'b1;
                illegal   = funct3[2] || funct3[1:0] == 2'b11;
            end
            OPC_BRANCH: begin
                branchDec = 1'b1;
                if (!funct3[2]) begin
                    aluOp = ALU_SUB;
                end else begin
                    aluOp = funct3[1] ? ALU_SLTU : ALU_SLT;
                end
                illegal = funct3[2:1] == 2'b01;
            end
            OPC_JAL: begin
                jumpDec  = 1'b1;
                regWrDec = 1'b1;
                wbSel    = WB_PC4;
            end
            OPC_JALR: begin
                jumpDec    = 1'b1;
                jumpRegDec = 1'b1;
                regWrDec   = 1'b1;
                aluSrcImm  = 1'b1;
                wbSel      = WB_PC4;
                illegal    = funct3 != 3'b000;
            end
            OPC_LUI: begin
                regWrDec  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = ALU_PASS_B;
                wbSel     = WB_IMM;
            end
            OPC_AUIPC: begin
                // cpu feeds pc into operand a for this opcode
                regWrDec  = 1'b1;
                aluSrcImm = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // beq/bne look at zero, the rest at less; funct3[0] inverts
    assign condMet = funct3[2] ? (aluLess ^ funct3[0]) : (aluZero ^ funct3[0]);

    assign misaligned = isAccess &&
                        ((memSize == SIZE_HALF && addrLow[0]) ||
                         (memSize == SIZE_WORD && addrLow != 2'b00));

    assign except      = illegal || misaligned;
    assign memWr       = memWrDec && !except;
    assign regWr       = regWrDec && !except;
    assign jump        = jumpDec && !except;
    assign jumpReg     = jumpRegDec && !except;
    assign branchTaken = branchDec && condMet && !except;

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rvPkg::wordT  a,
    input  rvPkg::wordT  b,
    input  rvPkg::aluOpT op,
    output rvPkg::wordT  result,
    output logic         zero,
    output logic         less
);
    import rvPkg::*;

    // unsigned only for SLTU, which also covers bltu/bgeu
    assign less = (op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << b[4:0];
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, less};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, less};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = wordT'($signed(a) >>> b[4:0]);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    assign zero = result == '0;

endmodule

`default_nettype wire

//--- immDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module immDecoder (
    input  rvPkg::wordT instruction,
    output rvPkg::wordT imm
);
    import rvPkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instruction[6:0]);

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR:
                imm = {{20{instruction[31]}}, instruction[31:20]};
            OPC_STORE:
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            OPC_BRANCH:
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {instruction[31:12], 12'b0};
            OPC_JAL:
                imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            // R-type has no immediate
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic        clk,
    input  logic [4:0]  rdAddr1,
    input  logic [4:0]  rdAddr2,
    input  logic [4:0]  wrAddr,
    input  rvPkg::wordT wrData,
    input  logic        wrEn,
    output rvPkg::wordT rdData1,
    output rvPkg::wordT rdData2
);
    import rvPkg::*;

    wordT regs [32];

    // x0 never written, and masked on read anyway
    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdData1 = (rdAddr1 == 5'd0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == 5'd0) ? '0 : regs[rdAddr2];

endmodule

`default_nettype wire

//--- loadStoreAlign.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreAlign (
    input  logic [1:0]  addrLow,
    input  rvPkg::sizeT size,
    input  logic        loadUnsigned,
    input  rvPkg::wordT storeData,
    input  rvPkg::wordT readWord,
    output rvPkg::wordT writeData,
    output rvPkg::maskT wrMask,
    output rvPkg::wordT loadData
);
    import rvPkg::*;

    logic [4:0]  laneShift;
    wordT        shiftedRead;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    // byte offset in bits
    assign laneShift   = {addrLow, 3'b000};
    assign shiftedRead = readWord >> laneShift;
    assign loadByte    = shiftedRead[7:0];
    assign loadHalf    = shiftedRead[15:0];

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                writeData = storeData << laneShift;
                wrMask    = maskT'(4'b0001 << addrLow);
                loadData  = {{24{loadByte[7] && !loadUnsigned}}, loadByte};
            end
            SIZE_HALF: begin
                writeData = storeData << laneShift;
                wrMask    = maskT'(4'b0011 << addrLow);
                loadData  = {{16{loadHalf[15] && !loadUnsigned}}, loadHalf};
            end
            default: begin
                writeData = storeData;
                wrMask    = 4'b1111;
                loadData  = readWord;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu #(
    parameter rvPkg::wordT RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  rvPkg::wordT instruction,
    input  rvPkg::wordT memReadData,
    output rvPkg::wordT pc,
    output rvPkg::wordT memAddr,
    output rvPkg::wordT memWriteData,
    output rvPkg::maskT wrMask,
    output logic        memWr,
    output logic        except
);
    import rvPkg::*;

    aluOpT aluOp;
    sizeT  memSize;
    wbSelT wbSel;
    logic  aluSrcImm;
    logic  jump;
    logic  jumpReg;
    logic  branchTaken;
    logic  loadUnsigned;
    logic  memWrCtrl;
    logic  regWr;
    logic  aluZero;
    logic  aluLess;
    wordT  imm;
    wordT  rs1Data;
    wordT  rs2Data;
    wordT  aluA;
    wordT  aluB;
    wordT  aluResult;
    wordT  loadData;
    wordT  wbData;
    wordT  pcPlus4;
    wordT  nextPc;

    controller u_controller (
        .instruction  (instruction),
        .addrLow      (aluResult[1:0]),
        .aluZero      (aluZero),
        .aluLess      (aluLess),
        .aluOp        (aluOp),
        .aluSrcImm    (aluSrcImm),
        .jump         (jump),
        .jumpReg      (jumpReg),
        .branchTaken  (branchTaken),
        .memSize      (memSize),
        .loadUnsigned (loadUnsigned),
        .memWr        (memWrCtrl),
        .regWr        (regWr),
        .wbSel        (wbSel),
        .except       (except)
    );

    immDecoder u_immDecoder (
        .instruction (instruction),
        .imm         (imm)
    );

    registerFile u_registerFile (
        .clk     (clk),
        .rdAddr1 (instruction[19:15]),
        .rdAddr2 (instruction[24:20]),
        .wrAddr  (instruction[11:7]),
        .wrData  (wbData),
        .wrEn    (regWr && !reset),
        .rdData1 (rs1Data),
        .rdData2 (rs2Data)
    );

    alu u_alu (
        .a      (aluA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero),
        .less   (aluLess)
    );

    loadStoreAlign u_loadStoreAlign (
        .addrLow      (aluResult[1:0]),
        .size         (memSize),
        .loadUnsigned (loadUnsigned),
        .storeData    (rs2Data),
        .readWord     (memReadData),
        .writeData    (memWriteData),
        .wrMask       (wrMask),
        .loadData     (loadData)
    );

    // auipc adds the immediate to pc instead of rs1
    assign aluA = (instruction[6:0] == OPC_AUIPC) ? pc : rs1Data;
    assign aluB = aluSrcImm ? imm : rs2Data;

    assign memAddr = aluResult;
    assign memWr   = memWrCtrl && !reset;
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (wbSel)
            WB_MEM:  wbData = loadData;
            WB_PC4:  wbData = pcPlus4;
            WB_IMM:  wbData = imm;
            default: wbData = aluResult;
        endcase
    end

    always_comb begin
        if (jumpReg) begin
            nextPc = {aluResult[31:1], 1'b0};
        end else if (jump || branchTaken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  rvPkg::wordT addr,
    input  rvPkg::wordT wrData,
    input  rvPkg::maskT wrMask,
    input  logic        wrEn,
    output rvPkg::wordT rdData
);
    import rvPkg::*;

    localparam int ADDR_BITS = $clog2(DMEM_WORDS);

    wordT                 mem [DMEM_WORDS];
    logic [ADDR_BITS-1:0] wordIdx;

    // drop the byte offset, upper bits wrap
    assign wordIdx = addr[ADDR_BITS+1:2];
    assign rdData  = mem[wordIdx];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wrEn && wrMask[lane]) begin
                mem[wordIdx][lane*8 +: 8] <= wrData[lane*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- rvSystem.sv
`timescale 1ns/1ps
`default_nettype none

module rvSystem #(
    parameter int          IMEM_WORDS = 256,
    parameter int          DMEM_WORDS = 256,
    parameter rvPkg::wordT RESET_PC   = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        imemWr,
    input  rvPkg::wordT imemAddr,
    input  rvPkg::wordT imemData,
    output rvPkg::wordT pc,
    output logic        memWr,
    output rvPkg::wordT memAddr,
    output rvPkg::wordT memWriteData,
    output rvPkg::maskT wrMask,
    output logic        except
);
    import rvPkg::*;

    localparam int IMEM_BITS = $clog2(IMEM_WORDS);

    wordT imem [IMEM_WORDS];
    wordT instruction;
    wordT memReadData;

    // program load, byte address like pc; only honoured during reset
    always_ff @(posedge clk) begin
        if (reset && imemWr) begin
            imem[imemAddr[IMEM_BITS+1:2]] <= imemData;
        end
    end

    assign instruction = imem[pc[IMEM_BITS+1:2]];

    cpu #(
        .RESET_PC (RESET_PC)
    ) u_cpu (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .memReadData  (memReadData),
        .pc           (pc),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .wrMask       (wrMask),
        .memWr        (memWr),
        .except       (except)
    );

    dataMemory #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dataMemory (
        .clk    (clk),
        .addr   (memAddr),
        .wrData (memWriteData),
        .wrMask (wrMask),
        .wrEn   (memWr),
        .rdData (memReadData)
    );

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- rvSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvSystemTb;
    import rvPkg::*;

    localparam int          CLK_PERIOD      = 40;
    localparam int          WATCHDOG_MARGIN = 50;
    localparam int unsigned SEED            = 32'h4545;
    localparam wordT        RESET_PC        = 32'h0000_0000;
    localparam wordT        BASE            = 32'h0000_0100;
    localparam wordT        MARK_TAKEN      = 32'h0000_7A7A;
    localparam wordT        MARK_FALL       = 32'h0000_0F0F;
    localparam wordT        OPND_NEG        = 32'hFFFF_FFFB;
    localparam wordT        OPND_POS        = 32'h0000_0003;

    logic clk;
    logic reset;
    logic imemWr;
    wordT imemAddr;
    wordT imemData;
    wordT pc;
    logic memWr;
    wordT memAddr;
    wordT memWriteData;
    maskT wrMask;
    logic except;

    // program image and expected store events of the current test
    wordT prog[$];
    wordT expAddr[$];
    wordT expData[$];
    maskT expMask[$];
    wordT excPcs[$];

    // what the DUT did
    wordT obsAddr[$];
    wordT obsData[$];
    maskT obsMask[$];
    wordT tracePc[$];
    logic traceExc[$];

    int checks;
    int errors;
    int watchdogBudget = 0;
    int elapsedCycles;

    tbClock #(
        .PERIOD_NS (CLK_PERIOD)
    ) u_tbClock (
        .clk (clk)
    );

    rvSystem #(
        .RESET_PC (RESET_PC)
    ) i_rvSystem (
        .clk          (clk),
        .reset        (reset),
        .imemWr       (imemWr),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .pc           (pc),
        .memWr        (memWr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .wrMask       (wrMask),
        .except       (except)
    );

    // sample mid low phase while values are stable
    always @(negedge clk) begin
        #1;
        if (!reset) begin
            tracePc.push_back(pc);
            traceExc.push_back(except);
            if (memWr) begin
                obsAddr.push_back(memAddr);
                obsData.push_back(memWriteData);
                obsMask.push_back(wrMask);
            end
        end
    end

    task automatic checkWord(input wordT actual, input wordT expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic checkMask(input maskT actual, input maskT expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, actual, expected);
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, msg, actual, expected);
        end
    endtask

    // instruction encoders
    function automatic wordT encR(input int f7, input int rs2, input int rs1,
                                  input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_OP};
    endfunction

    function automatic wordT encI(input wordT imm, input int rs1, input int f3,
                                  input int rd, input opcodeT opc);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic wordT encS(input wordT imm, input int rs2, input int rs1, input int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], OPC_STORE};
    endfunction

    function automatic wordT encB(input wordT imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic wordT encU(input logic [19:0] imm, input int rd, input opcodeT opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic wordT encJ(input wordT imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic wordT pcNow();
        return RESET_PC + wordT'(prog.size() * 4);
    endfunction

    task automatic emit(input wordT instr);
        prog.push_back(instr);
    endtask

    task automatic expectStore(input wordT addr, input wordT data, input maskT mask);
        expAddr.push_back(addr);
        expData.push_back(data);
        expMask.push_back(mask);
    endtask

    // upper part absorbs the carry of the sign-extended addi
    task automatic loadConst(input int rd, input wordT value);
        wordT lower;
        wordT upper;
        lower = {{20{value[11]}}, value[11:0]};
        upper = value - lower;
        emit(encU(upper[31:12], rd, OPC_LUI));
        emit(encI(lower, rd, 0, rd, OPC_OP_IMM));
    endtask

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        expMask.delete();
        excPcs.delete();
        // a store at the reset pc, held off while reset is high
        emit(encS(0, 0, 0, 2));
        expectStore(32'h0000_0000, 32'h0000_0000, 4'b1111);
        loadConst(10, BASE);
    endtask

    task automatic compareResults(input string name);
        int n;
        int hits;
        logic isExc;
        checkWord(wordT'(obsAddr.size()), wordT'(expAddr.size()), {name, " store count"});
        n = (obsAddr.size() < expAddr.size()) ? obsAddr.size() : expAddr.size();
        for (int i = 0; i < n; i++) begin
            checkWord(obsAddr[i], expAddr[i], {name, " store address"});
            checkWord(obsData[i], expData[i], {name, " store data"});
            checkMask(obsMask[i], expMask[i], {name, " store mask"});
        end
        hits = 0;
        foreach (tracePc[i]) begin
            isExc = 1'b0;
            foreach (excPcs[j]) begin
                if (excPcs[j] == tracePc[i]) begin
                    isExc = 1'b1;
                end
            end
            if (isExc) begin
                hits++;
            end
            checkFlag(traceExc[i], isExc, {name, " except"});
        end
        checkWord(wordT'(hits), wordT'(excPcs.size()), {name, " exception cycles"});
    endtask

    // load under reset, release, wait for the halt loop
    task automatic runProgram(input string name);
        wordT haltPc;
        int   limit;
        int   cycles;
        haltPc = pcNow();
        emit(encJ(0, 0));
        watchdogBudget += 2 * prog.size() + 20;
        @(negedge clk);
        reset = 1'b1;
        obsAddr.delete();
        obsData.delete();
        obsMask.delete();
        tracePc.delete();
        traceExc.delete();
        foreach (prog[i]) begin
            imemWr   = 1'b1;
            imemAddr = RESET_PC + wordT'(i * 4);
            imemData = prog[i];
            @(negedge clk);
        end
        imemWr = 1'b0;
        repeat (3) @(negedge clk);
        checkWord(pc, RESET_PC, {name, " pc in reset"});
        checkFlag(memWr, 1'b0, {name, " memWr in reset"});
        reset  = 1'b0;
        limit  = prog.size() + 10;
        cycles = 0;
        while (pc != haltPc && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        #2;
        if (pc != haltPc) begin
            errors++;
            $display("program %s did not reach its halt address within %0d cycles",
                     name, limit);
        end
        compareResults(name);
    endtask

    function automatic wordT arithInstr(input int k, input wordT b, input wordT imm);
        case (k)
            0:       return encR(0, 2, 1, 0, 5);
            1:       return encR(32, 2, 1, 0, 5);
            2:       return encR(0, 2, 1, 1, 5);
            3:       return encR(0, 2, 1, 2, 5);
            4:       return encR(0, 2, 1, 3, 5);
            5:       return encR(0, 2, 1, 4, 5);
            6:       return encR(0, 2, 1, 5, 5);
            7:       return encR(32, 2, 1, 5, 5);
            8:       return encR(0, 2, 1, 6, 5);
            9:       return encR(0, 2, 1, 7, 5);
            10:      return encI(imm, 1, 0, 5, OPC_OP_IMM);
            default: return encI({20'b0, 7'h20, b[4:0]}, 1, 5, 5, OPC_OP_IMM);
        endcase
    endfunction

    function automatic wordT arithExpect(input int k, input wordT a, input wordT b,
                                         input wordT imm);
        case (k)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return wordT'(($signed(a) < $signed(b)) ? 1 : 0);
            4:       return wordT'((a < b) ? 1 : 0);
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return wordT'($signed(a) >>> b[4:0]);
            8:       return a | b;
            9:       return a & b;
            10:      return a + {{20{imm[11]}}, imm[11:0]};
            default: return wordT'($signed(a) >>> b[4:0]);
        endcase
    endfunction

    task automatic testArithmetic();
        wordT a;
        wordT b;
        wordT imm;
        int   off;
        startProgram();
        off = 0;
        for (int pass = 0; pass < 2; pass++) begin
            a   = $urandom();
            b   = $urandom();
            imm = $urandom();
            loadConst(1, a);
            loadConst(2, b);
            for (int k = 0; k < 12; k++) begin
                emit(arithInstr(k, b, imm));
                emit(encS(off, 5, 10, 2));
                expectStore(BASE + off, arithExpect(k, a, b, imm), 4'b1111);
                off += 4;
            end
        end
        runProgram("arithmetic");
    endtask

    function automatic wordT loadExpect(input wordT word, input int o, input int f3);
        wordT lane;
        lane = word >> (8 * o);
        case (f3)
            0:       return {{24{lane[7]}}, lane[7:0]};
            4:       return {24'b0, lane[7:0]};
            1:       return {{16{lane[15]}}, lane[15:0]};
            default: return {16'b0, lane[15:0]};
        endcase
    endfunction

    task automatic testLoads();
        wordT word;
        int   off;
        startProgram();
        // bytes 0 and 2 positive, byte 1 negative, upper half positive
        word = ($urandom() | 32'h0000_8000) & ~32'h8080_0080;
        loadConst(1, word);
        emit(encS(0, 1, 10, 2));
        expectStore(BASE, word, 4'b1111);
        off = 4;
        for (int o = 0; o < 4; o++) begin
            for (int f3 = 0; f3 < 6; f3++) begin
                if (f3 == 0 || f3 == 4 || ((f3 == 1 || f3 == 5) && o % 2 == 0)) begin
                    emit(encI(o, 10, f3, 5, OPC_LOAD));
                    emit(encS(off, 5, 10, 2));
                    expectStore(BASE + off, loadExpect(word, o, f3), 4'b1111);
                    off += 4;
                end
            end
        end
        runProgram("loads");
    endtask

    task automatic testStores();
        wordT data;
        startProgram();
        data = $urandom();
        loadConst(1, data);
        for (int o = 0; o < 4; o++) begin
            emit(encS(o, 1, 10, 0));
            expectStore(BASE + o, data << (8 * o), maskT'(4'b0001 << o));
        end
        for (int o = 0; o < 4; o += 2) begin
            emit(encS(o, 1, 10, 1));
            expectStore(BASE + o, data << (8 * o), maskT'(4'b0011 << o));
        end
        runProgram("stores");
    endtask

    function automatic logic branchExpect(input int f3, input wordT a, input wordT b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one marker store per case whose value tells the path
    task automatic branchCase(input int f3, input int rsA, input wordT aVal,
                              input int rsB, input wordT bVal, input int off);
        emit(encB(12, rsB, rsA, f3));
        emit(encS(off, 20, 10, 2));
        emit(encJ(8, 0));
        emit(encS(off, 21, 10, 2));
        expectStore(BASE + off, branchExpect(f3, aVal, bVal) ? MARK_TAKEN : MARK_FALL,
                    4'b1111);
    endtask

    task automatic testControlFlow();
        int   kinds[6];
        int   off;
        wordT pcLink;
        startProgram();
        loadConst(1, OPND_NEG);
        loadConst(2, OPND_POS);
        loadConst(3, OPND_POS);
        loadConst(20, MARK_FALL);
        loadConst(21, MARK_TAKEN);
        kinds = '{0, 1, 4, 5, 6, 7};
        off   = 0;
        foreach (kinds[i]) begin
            branchCase(kinds[i], 1, OPND_NEG, 2, OPND_POS, off);
            branchCase(kinds[i], 2, OPND_POS, 1, OPND_NEG, off + 4);
            branchCase(kinds[i], 2, OPND_POS, 3, OPND_POS, off + 8);
            off += 12;
        end
        pcLink = pcNow();
        emit(encJ(8, 5));
        emit(encS(off, 20, 10, 2));
        emit(encS(off, 5, 10, 2));
        expectStore(BASE + off, pcLink + 4, 4'b1111);
        off += 4;
        // jalr follows the two-word constant and its target has bit 0 set
        pcLink = pcNow() + 8;
        loadConst(7, pcLink + 13);
        emit(encI(0, 7, 0, 6, OPC_JALR));
        emit(encS(off, 20, 10, 2));
        emit(encS(off, 21, 10, 2));
        emit(encS(off, 6, 10, 2));
        expectStore(BASE + off, pcLink + 4, 4'b1111);
        runProgram("control flow");
    endtask

    task automatic testUpper();
        wordT luiImm;
        wordT auiImm;
        wordT pcAuipc;
        startProgram();
        luiImm = $urandom();
        auiImm = $urandom();
        emit(encU(luiImm[19:0], 5, OPC_LUI));
        emit(encS(0, 5, 10, 2));
        expectStore(BASE, {luiImm[19:0], 12'b0}, 4'b1111);
        pcAuipc = pcNow();
        emit(encU(auiImm[19:0], 6, OPC_AUIPC));
        emit(encS(4, 6, 10, 2));
        expectStore(BASE + 4, pcAuipc + {auiImm[19:0], 12'b0}, 4'b1111);
        runProgram("lui auipc");
    endtask

    task automatic testExceptions();
        wordT keep;
        wordT badOp;
        startProgram();
        keep = $urandom();
        loadConst(5, keep);
        loadConst(1, ~keep);
        // store-shaped word with an undefined opcode
        badOp      = encS(0, 1, 10, 2);
        badOp[6:0] = 7'b0101011;
        excPcs.push_back(pcNow());
        emit(badOp);
        emit(encS(0, 5, 10, 2));
        expectStore(BASE, keep, 4'b1111);
        // misaligned lw reads a word unlike x5 and must leave x5 alone
        emit(encS(4, 1, 10, 2));
        expectStore(BASE + 4, ~keep, 4'b1111);
        excPcs.push_back(pcNow());
        emit(encI(5, 10, 2, 5, OPC_LOAD));
        emit(encS(8, 5, 10, 2));
        expectStore(BASE + 8, keep, 4'b1111);
        excPcs.push_back(pcNow());
        emit(encS(2, 1, 10, 2));
        emit(encS(12, 5, 10, 2));
        expectStore(BASE + 12, keep, 4'b1111);
        runProgram("exceptions");
    endtask

    initial begin
        reset    = 1'b1;
        imemWr   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        checks   = 0;
        errors   = 0;
        void'($urandom(SEED));
        testArithmetic();
        testLoads();
        testStores();
        testControlFlow();
        testUpper();
        testExceptions();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // budget grows as each test registers its program length
    initial begin
        elapsedCycles = 0;
        while (elapsedCycles <= watchdogBudget + WATCHDOG_MARGIN) begin
            @(posedge clk);
            elapsedCycles++;
        end
        $display("watchdog expired after %0d cycles, the run did not finish", elapsedCycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- rvSystem.f
rvPkg.sv
controller.sv
alu.sv
immDecoder.sv
registerFile.sv
loadStoreAlign.sv
cpu.sv
dataMemory.sv
rvSystem.sv
tbClock.sv
rvSystemTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
TOP       := rvSystemTb
FILELIST  := rvSystem.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BINARY    := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
